// ==== flist.f ====
logic/serial_tx_pkg.sv
logic/count_gen.sv
logic/oserdes_sdr.sv
logic/out_delay_line.sv
logic/serial_counter_tx.sv
sim/tb_serial_counter_tx.sv

// ==== Bender.yml ====
package:
  name: serial_counter_tx

sources:
  - files:
      - logic/serial_tx_pkg.sv
      - logic/count_gen.sv
      - logic/oserdes_sdr.sv
      - logic/out_delay_line.sv
      - logic/serial_counter_tx.sv
  - target: simulation
    files:
      - sim/tb_serial_counter_tx.sv

// ==== sim/tb_serial_counter_tx.sv ====
/*
 * Directed testbench for the serial count transmitter. Decodes data_o back
 * into words and checks count order, enable and lock gating, and the delay
 * tap controls. Stops at the first error.
 */

`timescale 1ns/1ps

module tb_serial_counter_tx;

   import serial_tx_pkg::*;

   localparam int unsigned WIDTH = 3;         // Word width under test
   localparam tap_t DELAY = 6'd4;             // Reset and load tap
   localparam int SLOW_NS = 20;               // pll_clk_div3 period
   localparam int FAST_NS = 6;                // pll_clk period
   localparam int QUIET_FAST = TAP_MAX + 2 * WIDTH + 4;   // Idle pin run, fast cycles
   localparam int DRAIN_CYC = (QUIET_FAST + TAP_MAX) * FAST_NS / SLOW_NS + 4;

   logic pll_clk_div3;
   logic pll_clk;
   logic reset_buf_n;
   logic enable;
   logic pll_lock;
   logic dly_load;
   logic dly_adj;
   logic dly_incdec;
   tap_t dly_tap;
   wire  data_o;

   logic [31:0]      rng_state = 32'h30d2_3ef6;
   int               errors = 0;
   int               cycle_cnt = 0;
   int               cycle_limit = 0;         // Armed once lengths are known
   int               quiet_cnt = 0;           // Fast cycles since last bit
   int               bit_total = 0;
   logic             bit_buf[$];              // Bits of the word in progress
   logic [WIDTH-1:0] word_q[$];               // Decoded words, oldest first
   logic [WIDTH-1:0] next_word = '0;          // Expected next word
   tap_t             exp_tap;
   int               idle_len;
   int               run_words;
   int               resume_words;
   int               nolock_len;
   int               lock_words;
   int               adj_count;
   int               final_words;

   serial_counter_tx #(.WIDTH(WIDTH), .DELAY(DELAY)) dut (
      .pll_clk_div3 (pll_clk_div3),
      .pll_clk      (pll_clk),
      .reset_buf_n  (reset_buf_n),
      .enable       (enable),
      .pll_lock     (pll_lock),
      .dly_load     (dly_load),
      .dly_adj      (dly_adj),
      .dly_incdec   (dly_incdec),
      .dly_tap      (dly_tap),
      .data_o       (data_o)
   );

   always #(SLOW_NS / 2) pll_clk_div3 = ~pll_clk_div3;
   always #(FAST_NS / 2) pll_clk = ~pll_clk;

   // **************************************************************************
   // Helpers and compare tasks
   // **************************************************************************

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int pick_len(input int lo, input int hi);
      rng_state = xorshift32(rng_state);
      return lo + int'(rng_state % (hi - lo + 1));
   endfunction

   // Tap rules: load wins, adjust steps by one and saturates
   function automatic tap_t predict_tap(input tap_t cur, input logic load, input logic adj,
                                        input logic up);
      if (load) return DELAY;
      if (!adj) return cur;
      if (up) return (cur == TAP_MAX) ? cur : cur + 1'b1;
      return (cur == 6'd0) ? cur : cur - 1'b1;
   endfunction

   task automatic stop_on_error(input string line);
      errors++;
      $display("%s", line);
      $display("TESTBENCH FAILED");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic check_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                             input string what);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                 $time, what, got, exp));
   endtask

   task automatic check_tap(input tap_t got, input tap_t exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                 $time, what, got, exp));
   endtask

   task automatic check_pin(input logic got, input logic exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                 $time, what, got, exp));
   endtask

   // Sample mid-bit, away from the pll_clk edge that moves data_o
   always @(negedge pll_clk) begin : decoder
      logic [WIDTH-1:0] w;
      if (data_o === 1'bz) begin
         quiet_cnt++;
      end else begin
         if (data_o === 1'bx) stop_on_error("data_o went unknown during a burst");
         quiet_cnt = 0;
         bit_total++;
         bit_buf.push_back(data_o);
         if (bit_buf.size() == WIDTH) begin
            for (int i = 0; i < WIDTH; i++) w[i] = bit_buf[i];   // LSB came first
            word_q.push_back(w);
            bit_buf.delete();
         end
      end
   end

   always @(posedge pll_clk_div3) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit)
         stop_on_error($sformatf("Timeout after %0d fabric cycles waiting on the DUT",
                                 cycle_cnt));
   end

   // Pops n words, each one the previous plus one mod 2^WIDTH
   task automatic take_words(input int n, input bit skip_first);
      logic [WIDTH-1:0] w;
      while (word_q.size() < n) @(posedge pll_clk);
      for (int i = 0; i < n; i++) begin
         w = word_q.pop_front();
         if (skip_first && i == 0) next_word = w;   // Resync after dropped words
         else check_word(w, next_word, "decoded word");
         next_word = next_word + 1'b1;
      end
   endtask

   // Pin idle long enough that nothing is left in the delay line
   task automatic drain_output();
      while (quiet_cnt < QUIET_FAST) @(posedge pll_clk);
      if (bit_buf.size() != 0) stop_on_error("Partial word left on data_o");
      take_words(word_q.size(), 1'b0);
   endtask

   task automatic pulse_delay(input logic load, input logic adj, input logic up);
      @(negedge pll_clk);
      dly_load   = load;
      dly_adj    = adj;
      dly_incdec = up;
      @(negedge pll_clk);                     // Tap moved on the edge between
      dly_load = 1'b0;
      dly_adj  = 1'b0;
      exp_tap  = predict_tap(exp_tap, load, adj, up);
      check_tap(dly_tap, exp_tap, "dly_tap after control pulse");
   endtask

   // **************************************************************************
   // Directed tests
   // **************************************************************************

   task automatic test_reset_idle();
      repeat (16) begin
         @(negedge pll_clk_div3);
         check_pin(data_o, 1'bz, "data_o in reset");
      end
      reset_buf_n = 1'b1;
      repeat (idle_len) begin
         @(negedge pll_clk_div3);
         check_pin(data_o, 1'bz, "data_o idle after reset");
      end
      exp_tap = DELAY;
      check_tap(dly_tap, exp_tap, "dly_tap after reset");
      if (bit_total != 0) stop_on_error("Bits appeared on data_o with enable low");
   endtask

   task automatic test_count_stream();
      @(negedge pll_clk_div3);
      enable = 1'b1;
      take_words(run_words, 1'b0);            // First word is 0, wraps past 7
   endtask

   task automatic test_enable_pause();
      @(negedge pll_clk_div3);
      enable = 1'b0;
      drain_output();
      @(negedge pll_clk_div3);
      enable = 1'b1;
      take_words(resume_words, 1'b0);         // Continues from last word
      @(negedge pll_clk_div3);
      enable = 1'b0;
      drain_output();
   endtask

   task automatic test_lock_gate();
      int start_bits;
      start_bits = bit_total;
      @(negedge pll_clk_div3);
      pll_lock = 1'b0;
      enable   = 1'b1;
      repeat (nolock_len) @(negedge pll_clk_div3);
      if (bit_total != start_bits) stop_on_error("Bits appeared on data_o while unlocked");
      pll_lock = 1'b1;
      take_words(lock_words, 1'b1);
      @(negedge pll_clk_div3);
      enable = 1'b0;
      drain_output();
   endtask

   task automatic test_delay_control();
      repeat (TAP_MAX + 3) pulse_delay(1'b0, 1'b1, 1'b1);    // Saturate at top
      pulse_delay(1'b1, 1'b0, 1'b0);
      repeat (DELAY + 3) pulse_delay(1'b0, 1'b1, 1'b0);      // Saturate at zero
      pulse_delay(1'b1, 1'b1, 1'b0);                         // Load beats adjust
      repeat (adj_count) pulse_delay(1'b0, 1'b1, logic'(pick_len(0, 1)));
      $display("Streaming with dly_tap %0d", dly_tap);
      @(negedge pll_clk_div3);
      enable = 1'b1;
      take_words(final_words, 1'b0);
      @(negedge pll_clk_div3);
      enable = 1'b0;
      drain_output();
   endtask

   initial begin
      pll_clk_div3 = 1'b0;
      pll_clk      = 1'b0;
      reset_buf_n  = 1'b0;
      enable       = 1'b0;
      pll_lock     = 1'b1;
      dly_load     = 1'b0;
      dly_adj      = 1'b0;
      dly_incdec   = 1'b0;
      idle_len     = pick_len(5, 20);
      run_words    = pick_len(12, 24);
      resume_words = pick_len(4, 10);
      nolock_len   = pick_len(8, 20);
      lock_words   = pick_len(6, 12);
      adj_count    = pick_len(30, 60);
      final_words  = pick_len(10, 16);
      // Fabric cycles per test, doubled for the limit
      cycle_limit = 2 * (16 + idle_len + run_words + resume_words + nolock_len
                         + lock_words + final_words + 5 * DRAIN_CYC
                         + (TAP_MAX + DELAY + adj_count + 8) * 2 * FAST_NS / SLOW_NS);
      test_reset_idle();
      test_count_stream();
      test_enable_pause();
      test_lock_gate();
      test_delay_control();
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule : tb_serial_counter_tx

// ==== logic/serial_counter_tx.sv ====
/*
 * Transmit path top. A fabric counter feeds an SDR serializer whose
 * output runs through a tap delay line to a tri-state pin.
 * Clocks, lock and buffered reset and enable come from outside.
 */

`timescale 1ns/1ps

module serial_counter_tx #(
   parameter int unsigned         WIDTH = 3,     // Count word width, 3 to 10
   parameter serial_tx_pkg::tap_t DELAY = 6'd0   // Initial delay tap
) (
   input  logic                pll_clk_div3,  // Fabric clock
   input  logic                pll_clk,       // Fast serial clock
   input  logic                reset_buf_n,   // Async reset, active low
   input  logic                enable,        // Count enable, active high
   input  logic                pll_lock,      // PLL locked
   input  logic                dly_load,      // Delay controls on pll_clk
   input  logic                dly_adj,
   input  logic                dly_incdec,
   output serial_tx_pkg::tap_t dly_tap,       // Current delay tap
   output wire                 data_o         // Serial pin, tri-state
);

   logic [WIDTH-1:0] count;                   // Fabric word
   logic             count_valid;
   logic             ser_q;                   // Serializer out
   logic             ser_oe;
   logic             dly_q;                   // Delay line out
   logic             dly_oe;

   // **************************************************************************
   // Datapath
   // **************************************************************************

   count_gen #(.WIDTH(WIDTH)) u_count_gen (
      .pll_clk_div3 (pll_clk_div3),
      .reset_buf_n  (reset_buf_n),
      .enable       (enable),
      .count        (count),
      .count_valid  (count_valid)
   );

   oserdes_sdr #(.WIDTH(WIDTH)) u_oserdes (
      .pll_clk_div3 (pll_clk_div3),
      .pll_clk      (pll_clk),
      .reset_buf_n  (reset_buf_n),
      .pll_lock     (pll_lock),
      .count        (count),
      .count_valid  (count_valid),
      .ser_q        (ser_q),
      .ser_oe       (ser_oe)
   );

   out_delay_line #(.DELAY(DELAY)) u_delay (
      .pll_clk      (pll_clk),
      .reset_buf_n  (reset_buf_n),
      .dly_load     (dly_load),
      .dly_adj      (dly_adj),
      .dly_incdec   (dly_incdec),
      .ser_q        (ser_q),
      .ser_oe       (ser_oe),
      .dly_q        (dly_q),
      .dly_oe       (dly_oe),
      .dly_tap      (dly_tap)
   );

   // Pin floats between bursts
   assign data_o = dly_oe ? dly_q : 1'bz;

endmodule : serial_counter_tx

// ==== logic/out_delay_line.sv ====
/*
 * Programmable output delay of 0 to 63 pll_clk cycles.
 * Bit and output enable share the line so they stay aligned.
 * The tap is loaded, or stepped up and down with saturation.
 */

`timescale 1ns/1ps

module out_delay_line #(
   parameter serial_tx_pkg::tap_t DELAY = 6'd0   // Tap after reset or load
) (
   input  logic                pll_clk,       // Fast serial clock
   input  logic                reset_buf_n,   // Async reset, active low
   input  logic                dly_load,      // Reload DELAY, wins over adjust
   input  logic                dly_adj,       // Step the tap by one
   input  logic                dly_incdec,    // Step direction, 1 is up
   input  logic                ser_q,         // Serial bit in
   input  logic                ser_oe,        // Output enable in
   output logic                dly_q,         // Delayed bit
   output logic                dly_oe,        // Delayed enable
   output serial_tx_pkg::tap_t dly_tap        // Current tap
);

   import serial_tx_pkg::*;

   localparam int unsigned DEPTH = TAP_MAX;   // One stage per nonzero tap

   logic [DEPTH-1:0] line_q;                  // Bit history, [0] is 1 cycle old
   logic [DEPTH-1:0] line_oe;                 // Enable history

   // **************************************************************************
   // Tap control
   // **************************************************************************

   always_ff @(posedge pll_clk or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         dly_tap <= DELAY;
      end else if (dly_load) begin
         dly_tap <= DELAY;
      end else if (dly_adj) begin
         if (dly_incdec) begin
            if (dly_tap != TAP_MAX) begin
               dly_tap <= dly_tap + 1'b1;     // Saturate at top
            end
         end else if (dly_tap != '0) begin
            dly_tap <= dly_tap - 1'b1;        // Saturate at zero
         end
      end
   end

   // **************************************************************************
   // Delay stages
   // **************************************************************************

   always_ff @(posedge pll_clk or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         line_q  <= '0;
         line_oe <= '0;                       // No stale enable after reset
      end else begin
         line_q  <= {line_q[DEPTH-2:0], ser_q};
         line_oe <= {line_oe[DEPTH-2:0], ser_oe};
      end
   end

   // Tap zero bypasses the line
   always_comb begin
      if (dly_tap == '0) begin
         dly_q  = ser_q;
         dly_oe = ser_oe;
      end else begin
         dly_q  = line_q[dly_tap - 1'b1];     // Stage k holds k cycles delay
         dly_oe = line_oe[dly_tap - 1'b1];
      end
   end

endmodule : out_delay_line

// ==== logic/oserdes_sdr.sv ====
/*
 * SDR serializer. Captures each fabric word, crosses it to the PLL clock
 * with a toggle flag and shifts it out LSB first with an output enable.
 * Words arriving while the PLL is unlocked are dropped.
 */

`timescale 1ns/1ps

module oserdes_sdr #(
   parameter int unsigned WIDTH = 3           // Word width, 3 to 10
) (
   input  logic             pll_clk_div3,     // Fabric clock
   input  logic             pll_clk,          // Fast serial clock
   input  logic             reset_buf_n,      // Async reset, active low
   input  logic             pll_lock,         // PLL lock, gates loading
   input  logic [WIDTH-1:0] count,            // Parallel word
   input  logic             count_valid,      // Word strobe, fabric domain
   output logic             ser_q,            // Serial bit
   output logic             ser_oe            // High during a burst
);

   import serial_tx_pkg::*;

   localparam int unsigned CNT_W = $clog2(WIDTH);
   localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WIDTH - 1);

   // Fabric side
   logic [WIDTH-1:0] hold_word;               // Stable copy for the fast side
   logic             word_tog;                // Flips once per captured word

   // Fast side
   logic             tog_s1;                  // First sync stage
   logic             tog_s2;                  // Second sync stage
   logic             tog_s3;                  // Edge detect history
   logic             word_new;                // One pll_clk pulse per word
   logic             load;                    // Accepted word
   ser_state_e       state;
   logic [CNT_W-1:0] bit_cnt;                 // Bits already sent in burst
   logic [WIDTH-1:0] shift_reg;

   // **************************************************************************
   // Fabric clock domain
   // **************************************************************************

   always_ff @(posedge pll_clk_div3 or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         hold_word <= '0;
         word_tog  <= 1'b0;
      end else if (count_valid) begin
         hold_word <= count;                  // Held until the next word
         word_tog  <= ~word_tog;              // Announce to fast side
      end
   end

   // **************************************************************************
   // Crossing into pll_clk
   // **************************************************************************

   always_ff @(posedge pll_clk or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         tog_s1 <= 1'b0;
         tog_s2 <= 1'b0;
         tog_s3 <= 1'b0;
      end else begin
         tog_s1 <= word_tog;
         tog_s2 <= tog_s1;
         tog_s3 <= tog_s2;
      end
   end

   assign word_new = tog_s2 ^ tog_s3;         // Toggle seen after sync
   assign load     = word_new & pll_lock;     // Drop word when unlocked

   // **************************************************************************
   // Shift FSM
   // **************************************************************************

   always_ff @(posedge pll_clk or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         state     <= SER_IDLE;
         bit_cnt   <= '0;
         shift_reg <= '0;
      end else begin
         case (state)
            SER_IDLE: begin
               if (load) begin
                  shift_reg <= hold_word;     // hold_word settled by now
                  bit_cnt   <= '0;
                  state     <= SER_SHIFT;
               end
            end
            SER_SHIFT: begin
               if (bit_cnt == LAST_BIT) begin
                  if (load) begin             // Back to back burst
                     shift_reg <= hold_word;
                     bit_cnt   <= '0;
                  end else begin
                     state <= SER_IDLE;
                  end
               end else begin
                  shift_reg <= shift_reg >> 1;   // Next bit to LSB
                  bit_cnt   <= bit_cnt + 1'b1;
               end
            end
            default: state <= SER_IDLE;
         endcase
      end
   end

   assign ser_q  = shift_reg[0];              // LSB first
   assign ser_oe = (state == SER_SHIFT);

endmodule : oserdes_sdr

// ==== logic/count_gen.sv ====
/*
 * Free-running count source in the fabric clock domain.
 * Counts while enable is high and strobes count_valid with every new word.
 */

`timescale 1ns/1ps

module count_gen #(
   parameter int unsigned WIDTH = 3           // Count word width, 3 to 10
) (
   input  logic             pll_clk_div3,     // Fabric clock
   input  logic             reset_buf_n,      // Async reset, active low
   input  logic             enable,           // Count enable, buffered
   output logic [WIDTH-1:0] count,            // Word handed to the serializer
   output logic             count_valid       // High while count is fresh
);

   logic [WIDTH-1:0] cnt;                     // Running counter

   // Counter wraps mod 2^WIDTH and holds while disabled
   always_ff @(posedge pll_clk_div3 or negedge reset_buf_n) begin
      if (!reset_buf_n) begin
         cnt         <= '0;
         count       <= '0;
         count_valid <= 1'b0;
      end else begin
         count_valid <= enable;               // Registered enable is the strobe
         if (enable) begin
            count <= cnt;                     // Pre-increment value goes out
            cnt   <= cnt + 1'b1;              // Natural wrap
         end
      end
   end

endmodule : count_gen

// ==== logic/serial_tx_pkg.sv ====
/*
 * Shared types and constants for the serial count transmitter.
 * Modules import what they need inside the body. Port lists use scoped names.
 */

package serial_tx_pkg;

   // **************************************************************************
   // Delay line
   // **************************************************************************

   // Current tap count of the output delay line
   typedef logic [5:0] tap_t;

   // Highest legal tap, also the depth of the delay line
   localparam tap_t TAP_MAX = 6'd63;

   // **************************************************************************
   // Serializer
   // **************************************************************************

   // Serializer FSM, waiting for a word or shifting one out
   typedef enum logic {
      SER_IDLE  = 1'b0,                       // No burst, output disabled
      SER_SHIFT = 1'b1                        // Burst in progress, LSB first
   } ser_state_e;

endpackage : serial_tx_pkg
